/* design/axil_operand_writer.sv */
// ********************************************************************
// AXI4-Lite write side: joins AW and W into one write, decodes the
// operand register and launches samples into the datapath
// ********************************************************************
`timescale 1ns/1ns
`default_nettype none

module axil_operand_writer (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [sqrt_pkg::axil_addr_w-1:0]    awaddr,
    input  logic                                wvalid,
    output logic                                wready,
    input  logic [sqrt_pkg::axil_data_w-1:0]    wdata,
    input  logic [sqrt_pkg::axil_data_w/8-1:0]  wstrb,
    output logic                                bvalid,
    input  logic                                bready,
    output logic [1:0]                          bresp,
    input  logic                                space,          // a FIFO slot is free
    output logic                                sample_valid,
    output logic [sqrt_pkg::data_w-1:0]         sample,
    output logic                                reserve         // takes one credit
);

    logic accept;                                  // AW and W handshake together
    logic launch;                                  // write goes to the datapath

    // both channels present, no response outstanding, room for a result
    assign accept  = awvalid && wvalid && !bvalid && space;
    assign launch  = (awaddr == sqrt_pkg::addr_operand) && (wstrb[1:0] == 2'b11);
    assign awready = accept;
    assign wready  = accept;
    assign reserve = accept && launch;            // errored writes cost nothing

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bvalid       <= 1'b0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= accept && launch;     // one cycle after the handshake
            if (accept) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;                   // response taken
            end
        end
    end

    // response code and operand are captured once per accepted write
    always_ff @(posedge clk) begin
        if (accept) begin
            bresp  <= launch ? sqrt_pkg::resp_okay : sqrt_pkg::resp_slverr;
            sample <= wdata[sqrt_pkg::data_w-1:0]; // Q5.11 in the low half
        end
    end

    // the response holds with a stable code until the master takes it
    a_bresp_held: assert property (
        @(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bresp)
    ) else $error("write response dropped before bready");

endmodule

`default_nettype wire

/* design/axil_result_reader.sv */
// ********************************************************************
// result FIFO with credit accounting and the AXI4-Lite read side
// for the result and status registers
// ********************************************************************
`timescale 1ns/1ns
`default_nettype none

module axil_result_reader #(
    parameter int fifo_depth = 8
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              result_valid,
    input  logic [sqrt_pkg::data_w-1:0]       result,
    input  logic                              reserve,
    input  logic                              arvalid,
    output logic                              arready,
    input  logic [sqrt_pkg::axil_addr_w-1:0]  araddr,
    output logic                              rvalid,
    input  logic                              rready,
    output logic [sqrt_pkg::axil_data_w-1:0]  rdata,
    output logic [1:0]                        rresp,
    output logic                              space
);

    localparam int ptr_w = $clog2(fifo_depth);
    localparam int cnt_w = $clog2(fifo_depth + 1);

    logic [sqrt_pkg::data_w-1:0] fifo_mem [fifo_depth];
    logic [ptr_w-1:0]            wr_ptr;
    logic [ptr_w-1:0]            rd_ptr;
    logic [cnt_w-1:0]            fill;             // entries waiting
    logic [cnt_w-1:0]            credits;          // depth - fill - in flight
    logic                        ar_fire;
    logic                        pop;

    // wraps at any depth, not only powers of two
    function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(fifo_depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign arready = !rvalid;                     // one read outstanding at most
    assign ar_fire = arvalid && !rvalid;
    assign pop     = ar_fire && (araddr == sqrt_pkg::addr_result) && (fill != '0);
    assign space   = (credits != '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            fill    <= '0;
            credits <= cnt_w'(fifo_depth);        // all slots free
            rvalid  <= 1'b0;
        end else begin
            if (result_valid) wr_ptr <= ptr_next(wr_ptr);
            if (pop) rd_ptr <= ptr_next(rd_ptr);
            fill    <= fill + cnt_w'(result_valid) - cnt_w'(pop);
            credits <= credits - cnt_w'(reserve) + cnt_w'(pop);
            if (ar_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (result_valid) fifo_mem[wr_ptr] <= result;
        if (ar_fire) begin                        // rdata and rresp held after this
            case (araddr)
                sqrt_pkg::addr_result: begin
                    if (fill != '0) begin
                        rdata <= sqrt_pkg::axil_data_w'(fifo_mem[rd_ptr]);
                        rresp <= sqrt_pkg::resp_okay;
                    end else begin
                        rdata <= '0;              // empty FIFO
                        rresp <= sqrt_pkg::resp_slverr;
                    end
                end
                sqrt_pkg::addr_status: begin
                    rdata <= sqrt_pkg::axil_data_w'(fill);
                    rresp <= sqrt_pkg::resp_okay;
                end
                default: begin
                    rdata <= '0;
                    rresp <= sqrt_pkg::resp_slverr;
                end
            endcase
        end
    end

    // admission in the writer must have left a slot for every result
    a_push_not_full: assert property (
        @(posedge clk) disable iff (reset)
        result_valid |-> fill < cnt_w'(fifo_depth)
    ) else $error("push into a full result FIFO");

    a_credit_floor: assert property (
        @(posedge clk) disable iff (reset)
        reserve |-> credits != '0
    ) else $error("credit counter underflow");

endmodule

`default_nettype wire

/* design/seg_coef_if.sv */
// ********************************************************************
// operand plus its selected slope and intercept, segment select to MAC
// ********************************************************************
`timescale 1ns/1ns
`default_nettype none

interface seg_coef_if;

    logic                        valid;            // one pulse per operand, no stall
    logic [sqrt_pkg::data_w-1:0] x;                // operand, Q5.11
    logic [sqrt_pkg::data_w-1:0] slope;            // m of the selected segment
    logic [sqrt_pkg::data_w-1:0] intercept;        // c of the selected segment

    modport src (
        output valid,
        output x,
        output slope,
        output intercept
    );

    modport dst (
        input  valid,
        input  x,
        input  slope,
        input  intercept
    );

endinterface

`default_nettype wire

/* design/sqrt_accel_top.sv */
// ********************************************************************
// square-root accelerator top: AXI4-Lite slave around the segment
// select and multiply-add pipeline
// ********************************************************************
`timescale 1ns/1ns
`default_nettype none

module sqrt_accel_top #(
    parameter int fifo_depth = 8                   // result FIFO entries, 4 or more
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              awvalid,
    output logic                              awready,
    input  logic [sqrt_pkg::axil_addr_w-1:0]  awaddr,
    input  logic                              wvalid,
    output logic                              wready,
    input  logic [sqrt_pkg::axil_data_w-1:0]  wdata,
    input  logic [sqrt_pkg::axil_data_w/8-1:0] wstrb,
    output logic                              bvalid,
    input  logic                              bready,
    output logic [1:0]                        bresp,
    input  logic                              arvalid,
    output logic                              arready,
    input  logic [sqrt_pkg::axil_addr_w-1:0]  araddr,
    output logic                              rvalid,
    input  logic                              rready,
    output logic [sqrt_pkg::axil_data_w-1:0]  rdata,
    output logic [1:0]                        rresp
);

    logic                        sample_valid;
    logic [sqrt_pkg::data_w-1:0] sample;
    logic                        reserve;          // writer takes a credit
    logic                        space;            // reader has a credit left
    logic                        result_valid;
    logic [sqrt_pkg::data_w-1:0] result;

    seg_coef_if coef_link ();                      // select -> mac

    axil_operand_writer i_operand_writer (
        .clk          (clk),
        .reset        (reset),
        .awvalid      (awvalid),
        .awready      (awready),
        .awaddr       (awaddr),
        .wvalid       (wvalid),
        .wready       (wready),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .bvalid       (bvalid),
        .bready       (bready),
        .bresp        (bresp),
        .space        (space),
        .sample_valid (sample_valid),
        .sample       (sample),
        .reserve      (reserve)
    );

    sqrt_segment_select i_segment_select (
        .clk          (clk),
        .reset        (reset),
        .sample_valid (sample_valid),
        .sample       (sample),
        .coef         (coef_link.src)
    );

    sqrt_mac i_mac (
        .clk          (clk),
        .reset        (reset),
        .coef         (coef_link.dst),
        .result_valid (result_valid),
        .result       (result)
    );

    axil_result_reader #(
        .fifo_depth   (fifo_depth)
    ) i_result_reader (
        .clk          (clk),
        .reset        (reset),
        .result_valid (result_valid),
        .result       (result),
        .reserve      (reserve),
        .arvalid      (arvalid),
        .arready      (arready),
        .araddr       (araddr),
        .rvalid       (rvalid),
        .rready       (rready),
        .rdata        (rdata),
        .rresp        (rresp),
        .space        (space)
    );

endmodule

`default_nettype wire

/* design/sqrt_mac.sv */
// ********************************************************************
// multiply-add: y = m*x + c in Q5.11, product and sum registered
// ********************************************************************
`timescale 1ns/1ns
`default_nettype none

module sqrt_mac (
    input  logic                        clk,
    input  logic                        reset,
    seg_coef_if.dst                     coef,
    output logic                        result_valid,
    output logic [sqrt_pkg::data_w-1:0] result
);

    logic [2*sqrt_pkg::data_w-1:0] product;        // Q10.22
    logic                          m1_valid;
    logic [sqrt_pkg::data_w-1:0]   m1_prod;        // back to Q5.11
    logic [sqrt_pkg::data_w-1:0]   m1_icpt;
    logic [sqrt_pkg::data_w:0]     sum;            // extra bit catches carry

    assign product = coef.x * coef.slope;
    assign sum     = {1'b0, m1_prod} + {1'b0, m1_icpt};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            m1_valid     <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            m1_valid     <= coef.valid;
            result_valid <= m1_valid;
        end
    end

    always_ff @(posedge clk) begin
        m1_prod <= product[sqrt_pkg::frac_bits +: sqrt_pkg::data_w]; // truncate
        m1_icpt <= coef.intercept;
        result  <= sum[sqrt_pkg::data_w-1:0];
    end

    // the tables keep y below 32.0, so there is no saturation logic
    a_no_carry: assert property (
        @(posedge clk) disable iff (reset)
        m1_valid |-> !sum[sqrt_pkg::data_w]
    ) else $error("Q5.11 result overflow");

endmodule

`default_nettype wire

/* design/sqrt_pkg.sv */
// ********************************************************************
// sqrt accelerator package: Q5.11 format, segment tables, register
// map and AXI4-Lite response codes
// ********************************************************************
`default_nettype none

package sqrt_pkg;

    localparam int frac_bits = 11;                 // Q5.11
    localparam int data_w    = 16;                 // operand and result width
    localparam int seg_count = 9;                  // linear segments

    typedef logic [3:0] seg_idx_t;                 // 0 .. seg_count-1

    // segment i+1 starts at breakpoints[i]
    localparam logic [data_w-1:0] breakpoints [0:seg_count-2] = '{
        16'h0012,                                  // 0.0088
        16'h00C0,                                  // 0.0938
        16'h02EB,                                  // 0.3647
        16'h06E7,                                  // 0.8628
        16'h0DF8,                                  // 1.7461
        16'h16B9,                                  // 2.8403
        16'h22B3,                                  // 4.3374
        16'h31CE                                   // 6.2256
    };

    localparam logic [data_w-1:0] slopes [0:seg_count-1] = '{
        16'h538D,                                  // 10.444
        16'h13E3,                                  // 2.486
        16'h08C9,                                  // 1.098
        16'h0537,                                  // 0.652
        16'h038D,                                  // 0.444
        16'h02A9,                                  // 0.333
        16'h021F,                                  // 0.265
        16'h01BF,                                  // 0.218
        16'h0180                                   // 0.188
    };

    localparam logic [data_w-1:0] intercepts [0:seg_count-1] = '{
        16'h0000,                                  // 0.000
        16'h0095,                                  // 0.073
        16'h01A0,                                  // 0.203
        16'h02ED,                                  // 0.366
        16'h045D,                                  // 0.546
        16'h05ED,                                  // 0.741
        16'h0773,                                  // 0.931
        16'h0914,                                  // 1.135
        16'h0A9B                                   // 1.326
    };

    localparam int axil_addr_w = 4;                // byte address bits
    localparam int axil_data_w = 32;

    localparam logic [axil_addr_w-1:0] addr_operand = 4'h0;   // write only
    localparam logic [axil_addr_w-1:0] addr_result  = 4'h4;   // read pops the FIFO
    localparam logic [axil_addr_w-1:0] addr_status  = 4'h8;   // FIFO fill count

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

endpackage

`default_nettype wire

/* design/sqrt_segment_select.sv */
// ********************************************************************
// segment selection: compare against the breakpoints, then look up
// slope and intercept, two register stages
// ********************************************************************
`timescale 1ns/1ns
`default_nettype none

module sqrt_segment_select (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        sample_valid,
    input  logic [sqrt_pkg::data_w-1:0] sample,
    seg_coef_if.src                     coef
);

    sqrt_pkg::seg_idx_t          seg_idx;          // comparator result
    logic                        s1_valid;
    sqrt_pkg::seg_idx_t          s1_idx;
    logic [sqrt_pkg::data_w-1:0] s1_x;

    // index = number of breakpoints at or below the operand
    always_comb begin
        seg_idx = '0;
        for (int i = 0; i < sqrt_pkg::seg_count - 1; i++) begin
            if (sample >= sqrt_pkg::breakpoints[i]) begin
                seg_idx = seg_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s1_valid   <= 1'b0;
            coef.valid <= 1'b0;
        end else begin
            s1_valid   <= sample_valid;
            coef.valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_idx         <= seg_idx;                 // stage 1
        s1_x           <= sample;
        coef.x         <= s1_x;                    // stage 2, table lookup
        coef.slope     <= sqrt_pkg::slopes[s1_idx];
        coef.intercept <= sqrt_pkg::intercepts[s1_idx];
    end

    // the lookup address must stay inside the nine-entry tables
    a_idx_range: assert property (
        @(posedge clk) disable iff (reset)
        s1_valid |-> s1_idx <= sqrt_pkg::seg_idx_t'(sqrt_pkg::seg_count - 1)
    ) else $error("segment index out of range");

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the sqrt accelerator testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_sqrt_accel \
    -f tb.f -o tb_sqrt_accel
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sqrt_accel > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Testbench passed" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1

/* tb.f */
+incdir+verification
design/sqrt_pkg.sv
design/seg_coef_if.sv
design/axil_operand_writer.sv
design/sqrt_segment_select.sv
design/sqrt_mac.sv
design/axil_result_reader.sv
design/sqrt_accel_top.sv
verification/tb_sqrt_accel.sv

/* verification/sqrt_tb_tasks.svh */
// ********************************************************************
// AXI4-Lite master tasks, Q5.11 reference model and directed tests
// ********************************************************************
`ifndef sqrt_tb_tasks_svh
`define sqrt_tb_tasks_svh

task automatic check_equal(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("FAILED at %0t ns: %s got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
endtask

// y = m*x + c on the segment counted by the breakpoints at or below x
function automatic logic [15:0] model_sqrt(input logic [15:0] x);
    int          seg;
    logic [31:0] prod;
    logic [15:0] scaled;
    seg = 0;
    for (int i = 0; i < sqrt_pkg::seg_count - 1; i++) begin
        if (x >= sqrt_pkg::breakpoints[i]) seg = i + 1;
    end
    prod   = 32'(x) * 32'(sqrt_pkg::slopes[seg]);
    scaled = 16'(prod >> sqrt_pkg::frac_bits);     // truncate back to Q5.11
    return scaled + sqrt_pkg::intercepts[seg];
endfunction

task automatic drive_write(input logic [3:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    @(posedge clk);
    awvalid <= 1'b1;                               // address and data together
    awaddr  <= addr;
    wvalid  <= 1'b1;
    wdata   <= data;
    wstrb   <= strb;
    bready  <= 1'b0;
endtask

task automatic wait_write_accept(input int limit, output bit accepted);
    int waited;
    waited = 0;
    do begin
        @(negedge clk);                            // ready sampled mid cycle
        waited++;
    end while (!(awready && wready) && waited < limit);
    accepted = awready && wready;
    if (accepted) begin
        @(posedge clk);                            // handshake edge
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
    end
endtask

task automatic collect_bresp(input int hold, output logic [1:0] resp);
    int waited;
    waited = 0;
    resp   = 2'b11;                                // neither OKAY nor SLVERR
    do begin
        @(negedge clk);
        waited++;
    end while (!bvalid && waited < timeout_cycles);
    if (!bvalid) begin
        errors++;
        $display("timeout at %0t ns: no write response arrived", $time);
        return;
    end
    resp = bresp;
    repeat (hold) begin                            // bready held low
        @(negedge clk);
        checks++;
        if (!bvalid || bresp !== resp) begin
            errors++;
            $display("FAILED at %0t ns: write response changed before bready", $time);
        end
    end
    @(posedge clk);
    bready <= 1'b1;
    @(posedge clk);
    bready <= 1'b0;
endtask

task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                          input logic [3:0] strb, input int hold, output logic [1:0] resp);
    bit accepted;
    drive_write(addr, data, strb);
    wait_write_accept(timeout_cycles, accepted);
    if (!accepted) begin
        errors++;
        $display("timeout at %0t ns: write was never accepted", $time);
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        resp = 2'b11;
        return;
    end
    collect_bresp(hold, resp);
endtask

task automatic axil_read(input logic [3:0] addr, input int hold,
                         output logic [31:0] data, output logic [1:0] resp);
    int waited;
    data   = '0;
    resp   = 2'b11;
    waited = 0;
    @(posedge clk);
    arvalid <= 1'b1;
    araddr  <= addr;
    rready  <= 1'b0;
    do begin
        @(negedge clk);
        waited++;
    end while (!arready && waited < timeout_cycles);
    if (!arready) begin
        errors++;
        $display("timeout at %0t ns: read address was never accepted", $time);
        @(posedge clk);
        arvalid <= 1'b0;
        return;
    end
    @(posedge clk);                                // handshake edge
    arvalid <= 1'b0;
    waited = 0;
    do begin
        @(negedge clk);
        waited++;
    end while (!rvalid && waited < timeout_cycles);
    if (!rvalid) begin
        errors++;
        $display("timeout at %0t ns: no read response arrived", $time);
        return;
    end
    data = rdata;
    resp = rresp;
    repeat (hold) begin                            // rready held low
        @(negedge clk);
        checks++;
        if (!rvalid || rdata !== data || rresp !== resp) begin
            errors++;
            $display("FAILED at %0t ns: read response changed before rready", $time);
        end
    end
    @(posedge clk);
    rready <= 1'b1;
    @(posedge clk);
    rready <= 1'b0;
endtask

// poll status until it shows the expected fill or the poll limit is hit
task automatic wait_fill(input int expected);
    logic [31:0] data;
    logic [1:0]  resp;
    int          polls;
    polls = 0;
    do begin
        axil_read(sqrt_pkg::addr_status, 0, data, resp);
        polls++;
    end while (data != 32'(expected) && polls < 20);
    check_equal("status fill count", data, 32'(expected));
endtask

task automatic read_result(input logic [15:0] exp);
    logic [31:0] data;
    logic [1:0]  resp;
    axil_read(sqrt_pkg::addr_result, 0, data, resp);
    check_equal("result data", data, {16'h0000, exp});
    check_equal("result response", 32'(resp), 32'(sqrt_pkg::resp_okay));
endtask

task automatic single_point(input logic [15:0] x);
    logic [1:0] resp;
    axil_write(sqrt_pkg::addr_operand, {16'h0000, x}, 4'hF, 0, resp);
    check_equal("operand write response", 32'(resp), 32'(sqrt_pkg::resp_okay));
    wait_fill(1);
    read_result(model_sqrt(x));
endtask

task automatic reset_state_check();
    @(negedge clk);
    checks++;
    if (bvalid || rvalid) begin
        errors++;
        $display("FAILED at %0t ns: response valid high after reset", $time);
    end
    wait_fill(0);
endtask

task automatic segment_edges();
    logic [15:0] points[$];
    points.push_back(16'h0000);
    points.push_back(16'h0800);                    // 1.0
    points.push_back(16'h2000);                    // 4.0
    for (int i = 0; i < sqrt_pkg::seg_count - 1; i++) begin
        points.push_back(sqrt_pkg::breakpoints[i]);
        points.push_back(sqrt_pkg::breakpoints[i] - 16'd1);  // last x of previous segment
    end
    foreach (points[i]) single_point(points[i]);
endtask

task automatic random_batch();
    logic [15:0] exp[$];
    logic [15:0] x;
    logic [1:0]  resp;
    for (int i = 0; i < 8; i++) begin
        x = 16'($urandom);                         // whole Q5.11 range
        axil_write(sqrt_pkg::addr_operand, {16'h0000, x}, 4'hF, 0, resp);
        check_equal("batch write response", 32'(resp), 32'(sqrt_pkg::resp_okay));
        exp.push_back(model_sqrt(x));
    end
    wait_fill(8);
    foreach (exp[i]) read_result(exp[i]);
    wait_fill(0);
endtask

task automatic backpressure();
    logic [15:0] exp[$];
    logic [15:0] x;
    logic [1:0]  resp;
    bit          accepted;
    int          waited;
    for (int i = 0; i < fifo_depth; i++) begin
        x = 16'($urandom);
        axil_write(sqrt_pkg::addr_operand, {16'h0000, x}, 4'hF, 0, resp);
        exp.push_back(model_sqrt(x));
    end
    wait_fill(fifo_depth);
    x = 16'h1234;
    exp.push_back(model_sqrt(x));                  // must come out last
    drive_write(sqrt_pkg::addr_operand, {16'h0000, x}, 4'hF);
    wait_write_accept(50, accepted);
    checks++;
    if (accepted) begin
        errors++;
        $display("FAILED at %0t ns: write accepted while the FIFO was full", $time);
    end
    read_result(exp.pop_front());                  // frees one credit
    waited = 0;
    do begin
        @(negedge clk);
        waited++;
    end while (!bvalid && waited < timeout_cycles);
    if (!bvalid) begin
        errors++;
        $display("timeout at %0t ns: stalled write was never accepted", $time);
    end
    @(posedge clk);                                // bvalid blocks a second accept here
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    collect_bresp(0, resp);
    check_equal("stalled write response", 32'(resp), 32'(sqrt_pkg::resp_okay));
    wait_fill(fifo_depth);
    foreach (exp[i]) read_result(exp[i]);
endtask

task automatic error_responses();
    logic [31:0] data;
    logic [1:0]  resp;
    axil_write(4'hC, 32'h0000_0800, 4'hF, 0, resp);
    check_equal("unmapped write response", 32'(resp), 32'(sqrt_pkg::resp_slverr));
    axil_write(sqrt_pkg::addr_result, 32'h0000_0800, 4'hF, 0, resp);
    check_equal("write to result response", 32'(resp), 32'(sqrt_pkg::resp_slverr));
    axil_write(sqrt_pkg::addr_operand, 32'h0000_0800, 4'b0001, 0, resp);
    check_equal("partial strobe response", 32'(resp), 32'(sqrt_pkg::resp_slverr));
    axil_write(sqrt_pkg::addr_operand, 32'h0000_0800, 4'b1100, 0, resp);
    check_equal("upper strobe response", 32'(resp), 32'(sqrt_pkg::resp_slverr));
    repeat (8) @(posedge clk);                     // longer than the 5-cycle pipeline
    axil_read(sqrt_pkg::addr_status, 0, data, resp);
    check_equal("status after rejected writes", data, 32'd0);
    axil_read(sqrt_pkg::addr_result, 0, data, resp);
    check_equal("empty FIFO read data", data, 32'd0);
    check_equal("empty FIFO read response", 32'(resp), 32'(sqrt_pkg::resp_slverr));
    axil_read(4'hC, 0, data, resp);
    check_equal("unmapped read response", 32'(resp), 32'(sqrt_pkg::resp_slverr));
endtask

task automatic held_responses();
    logic [31:0] data;
    logic [1:0]  resp;
    axil_write(sqrt_pkg::addr_operand, 32'h0000_4A00, 4'hF, 6, resp);
    check_equal("held write response", 32'(resp), 32'(sqrt_pkg::resp_okay));
    wait_fill(1);
    axil_read(sqrt_pkg::addr_result, 6, data, resp);
    check_equal("held read data", data, {16'h0000, model_sqrt(16'h4A00)});
    check_equal("held read response", 32'(resp), 32'(sqrt_pkg::resp_okay));
endtask

`endif

/* verification/tb_sqrt_accel.sv */
// ********************************************************************
// testbench for the square-root accelerator: AXI4-Lite master, Q5.11
// reference model and directed tests with a closing error count
// ********************************************************************
`timescale 1ns/1ns
`default_nettype none

module tb_sqrt_accel;

    localparam int fifo_depth     = 8;
    localparam int timeout_cycles = 200;           // limit of every wait loop

    logic                                clk;
    logic                                reset;
    logic                                awvalid;
    logic                                awready;
    logic [sqrt_pkg::axil_addr_w-1:0]    awaddr;
    logic                                wvalid;
    logic                                wready;
    logic [sqrt_pkg::axil_data_w-1:0]    wdata;
    logic [sqrt_pkg::axil_data_w/8-1:0]  wstrb;
    logic                                bvalid;
    logic                                bready;
    logic [1:0]                          bresp;
    logic                                arvalid;
    logic                                arready;
    logic [sqrt_pkg::axil_addr_w-1:0]    araddr;
    logic                                rvalid;
    logic                                rready;
    logic [sqrt_pkg::axil_data_w-1:0]    rdata;
    logic [1:0]                          rresp;

    int errors;                                    // failed checks and timeouts
    int checks;

    always #5 clk = ~clk;                          // 10 ns period

    sqrt_accel_top #(
        .fifo_depth (fifo_depth)
    ) i_sqrt_accel_top (
        .clk     (clk),
        .reset   (reset),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

    `include "sqrt_tb_tasks.svh"

    initial begin
        clk     = 1'b0;
        errors  = 0;
        checks  = 0;
        reset   <= 1'b1;
        awvalid <= 1'b0;
        awaddr  <= '0;
        wvalid  <= 1'b0;
        wdata   <= '0;
        wstrb   <= '0;
        bready  <= 1'b0;
        arvalid <= 1'b0;
        araddr  <= '0;
        rready  <= 1'b0;
        void'($urandom(32'h3abed557));             // single seed for the run
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        reset_state_check();
        segment_edges();
        random_batch();
        backpressure();
        error_responses();
        held_responses();
        repeat (5) @(posedge clk);
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
